/* run_sim.sh */
#!/bin/sh
# build the background layer testbench with verilator, run it and look for the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module tb_bg -f tb.f -o tb_bg_sim &&
./obj_dir/tb_bg_sim | tee /dev/stderr | grep -qF '*** PASSED ***' &&
echo "simulation passed" ||
{
    echo "simulation failed"
    exit 1
}

/* sim/tb_bg.sv */
// testbench for the background layer with shadow memory, raster model, assertions and watchdog
`timescale 1ns/1ps

module tb_bg;

    localparam int CLK_HALF    = 4;
    localparam int CLK_PERIOD  = 2 * CLK_HALF;
    // one frame in clocks, two clocks per pixel
    localparam int FRAME_CLKS  = bg_pkg::H_TOTAL * bg_pkg::V_TOTAL * 2;
    // generous limit, the sequence needs about six frames
    localparam int WATCHDOG_NS = FRAME_CLKS * CLK_PERIOD * 8;
    localparam int MEM_WORDS   = bg_pkg::NUM_BANKS * (2 ** bg_pkg::ADDR_W);

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic                        cpu_cs_n;
    logic                        cpu_wr;
    logic [bg_pkg::ADDR_W:0]     cpu_addr;
    logic [bg_pkg::COLOR_W-1:0]  cpu_din;
    logic [7:0]                  scroll_x;
    logic [8:0]                  scroll_y;
    logic [bg_pkg::COLOR_W-1:0]  bakc;
    logic                        pxl_cen;
    logic [8:0]                  h_cnt;
    logic [8:0]                  v_cnt;
    logic                        hblank;
    logic                        vblank;

    // mirror of both banks, index is {bank, address}
    logic [bg_pkg::COLOR_W-1:0]  shadow [0:MEM_WORDS-1];
    // reference raster and scroll positions
    logic                        m_cen;
    logic [8:0]                  m_h;
    logic [8:0]                  m_v;
    logic [7:0]                  m_hpos;
    logic [8:0]                  m_vpos;
    // previous chip select level and colour for the hold check
    logic                        hold_arm;
    logic [bg_pkg::COLOR_W-1:0]  hold_val;
    logic [bg_pkg::COLOR_W-1:0]  exp_col;
    logic                        color_on;
    logic [31:0]                 lcg_state = 32'd24;
    string                       test_name = "reset";
    int                          errors = 0;

    bg_top i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .cpu_cs_n (cpu_cs_n),
        .cpu_wr   (cpu_wr),
        .cpu_addr (cpu_addr),
        .cpu_din  (cpu_din),
        .scroll_x (scroll_x),
        .scroll_y (scroll_y),
        .bakc     (bakc),
        .pxl_cen  (pxl_cen),
        .h_cnt    (h_cnt),
        .v_cnt    (v_cnt),
        .hblank   (hblank),
        .vblank   (vblank)
    );

    always #(CLK_HALF) clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic next_rand(output logic [15:0] value);
        lcg_state = lcg_step(lcg_state);
        value = lcg_state[30:15];
    endtask

    task automatic report_mismatch(input string what, input int expected, input int actual);
        errors++;
        $display("error: test %s, %s expected %0d actual %0d", test_name, what, expected, actual);
        $display("*** FAILED ***");
        $fatal(1, "stopped at the first mismatch");
    endtask

    // colour a tile boundary should have loaded for the pixel now on screen
    // previous tile column of the row given by vpos, off-field rows read entry 0
    function automatic logic [bg_pkg::COLOR_W-1:0] expected_colour(input logic [7:0] hpos,
                                                                   input logic [8:0] vpos);
        logic [5:0]                tile;
        logic [bg_pkg::ADDR_W-1:0] a;
        tile = hpos[7:2] - 6'd1;
        a = vpos[8] ? '0 : {vpos[6:1], tile};
        return shadow[{vpos[7], a}];
    endfunction

    // one cpu write with chip select already low, wr high one clock then low one clock
    task automatic cpu_write(input logic bank, input logic [11:0] a, input logic [3:0] d);
        cpu_addr <= {bank, a};
        cpu_din  <= d;
        cpu_wr   <= 1'b1;
        shadow[{bank, a}] = d;
        @(posedge clk);
        cpu_wr <= 1'b0;
        @(posedge clk);
    endtask

    task automatic wait_for_line(input int line);
        do begin
            @(posedge clk);
        end while (!(int'(v_cnt) == line && h_cnt == 9'd0));
    endtask

    // reference model and checks, pre-edge values sampled on every rising edge
    always @(posedge clk) begin
        if (!rst_n) begin
            m_cen    = 1'b0;
            m_h      = 9'd0;
            m_v      = 9'd0;
            m_hpos   = 8'd0;
            m_vpos   = 9'd0;
            hold_arm = 1'b0;
            hold_val = '0;
        end else begin
            assert (pxl_cen == m_cen) else report_mismatch("pxl_cen", int'(m_cen), int'(pxl_cen));
            assert (h_cnt == m_h) else report_mismatch("h_cnt", int'(m_h), int'(h_cnt));
            assert (v_cnt == m_v) else report_mismatch("v_cnt", int'(m_v), int'(v_cnt));
            assert (hblank == (m_h >= 9'(bg_pkg::H_VIS)))
                else report_mismatch("hblank", int'(m_h >= 9'(bg_pkg::H_VIS)), int'(hblank));
            assert (vblank == (m_v >= 9'(bg_pkg::V_VIS)))
                else report_mismatch("vblank", int'(m_v >= 9'(bg_pkg::V_VIS)), int'(vblank));
            // colour must not move while the cpu holds the chip select
            if (!cpu_cs_n && hold_arm) begin
                assert (bakc === hold_val)
                    else report_mismatch("bakc under cs", int'(hold_val), int'(bakc));
            end
            hold_arm = !cpu_cs_n;
            hold_val = bakc;
            // tile phase 1 of a visible pixel, previous tile is settled
            if (color_on && m_cen && m_v < 9'(bg_pkg::V_VIS) && m_h >= 9'd8 &&
                m_h < 9'(bg_pkg::H_VIS) && m_hpos[1:0] == 2'd1) begin
                exp_col = expected_colour(m_hpos, m_vpos);
                assert (bakc == exp_col) else report_mismatch("bakc", int'(exp_col), int'(bakc));
            end
            // advance the raster on pixel enables
            if (m_cen) begin
                if (m_h == 9'(bg_pkg::H_TOTAL - 1)) begin
                    m_h    = 9'd0;
                    m_vpos = m_v + 9'd1 + scroll_y;
                    m_v    = (m_v == 9'(bg_pkg::V_TOTAL - 1)) ? 9'd0 : m_v + 9'd1;
                end else begin
                    m_h = m_h + 9'd1;
                end
            end
            m_cen  = !m_cen;
            m_hpos = scroll_x + m_h[7:0];
        end
    end

    initial begin
        logic [15:0] rnd;
        rst_n    = 1'b1;
        cpu_cs_n = 1'b1;
        cpu_wr   = 1'b0;
        cpu_addr = '0;
        cpu_din  = '0;
        scroll_x = 8'd0;
        scroll_y = 9'd0;
        color_on = 1'b0;
        #1 rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        assert (bakc == '0) else report_mismatch("bakc after reset", 0, int'(bakc));

        // fill both banks with random colours during the first vblank
        test_name = "fill";
        wait_for_line(bg_pkg::V_VIS);
        cpu_cs_n <= 1'b0;
        @(posedge clk);
        for (int b = 0; b < bg_pkg::NUM_BANKS; b++) begin
            for (int a = 0; a < 2 ** bg_pkg::ADDR_W; a++) begin
                next_rand(rnd);
                cpu_write(1'(b), 12'(a), rnd[3:0]);
            end
        end
        cpu_cs_n <= 1'b1;

        // no scroll, mostly bank 0 rows
        test_name = "low bank";
        wait_for_line(0);
        color_on <= 1'b1;
        wait_for_line(bg_pkg::V_VIS);
        color_on <= 1'b0;

        // small vertical scroll pulls rows with vpos[7] set into view
        test_name = "high bank";
        next_rand(rnd);
        scroll_y <= 9'(rnd[4:0]);
        wait_for_line(0);
        color_on <= 1'b1;
        wait_for_line(bg_pkg::V_VIS);
        color_on <= 1'b0;

        // nonzero horizontal scroll wraps hpos inside every line
        test_name = "hscroll wrap";
        next_rand(rnd);
        scroll_x <= (rnd[7:0] == 8'd0) ? 8'd1 : rnd[7:0];
        scroll_y <= 9'd0;
        wait_for_line(0);
        color_on <= 1'b1;
        wait_for_line(bg_pkg::V_VIS);
        color_on <= 1'b0;

        // large vertical scroll reaches the off-field rows
        test_name = "off field";
        next_rand(rnd);
        scroll_x <= 8'd0;
        scroll_y <= 9'd200 + 9'(rnd[5:0]);
        wait_for_line(0);
        color_on <= 1'b1;
        wait_for_line(bg_pkg::V_VIS);
        color_on <= 1'b0;

        // chip select low across part of a visible line
        // line 100 back on the tile map, so the colour would move without the hold
        test_name = "cpu hold";
        scroll_y <= 9'd0;
        wait_for_line(100);
        repeat (5) @(posedge clk);
        cpu_cs_n <= 1'b0;
        repeat (300) @(posedge clk);
        cpu_cs_n <= 1'b1;
        wait_for_line(bg_pkg::V_VIS);

        if (errors == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("*** FAILED ***");
            $fatal(1, "checks failed");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within eight frames");
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule

/* tb.f */
verilog/bg_pkg.sv
verilog/video_timing.sv
verilog/bg_addr_gen.sv
verilog/bg_tile_bank.sv
verilog/bg_pixel_out.sv
verilog/bg_top.sv
sim/tb_bg.sv

/* verilog/bg_addr_gen.sv */
// background address generator with scroll counters, cpu write decode and shared bank address
`timescale 1ns/1ps

module bg_addr_gen (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                pxl_cen,
    input  logic                                line_load,
    input  logic [8:0]                          v_cnt,
    input  logic                                cpu_cs_n,
    input  logic                                cpu_wr,
    input  logic [bg_pkg::ADDR_W:0]             cpu_addr,
    input  logic [bg_pkg::COLOR_W-1:0]          cpu_din,
    input  logic [7:0]                          scroll_x,
    input  logic [8:0]                          scroll_y,
    output logic [bg_pkg::ADDR_W-1:0]           addr,
    output logic [bg_pkg::COLOR_W-1:0]          wdata,
    output logic [bg_pkg::NUM_BANKS-1:0]        bank_we,
    output logic [1:0]                          hpos_lo,
    output logic                                bank_sel
);

    // scrolled horizontal position within the 256 pixel playfield
    logic [7:0] hpos;
    // scrolled vertical position latched once per line
    logic [8:0] vpos;
    // previous cpu_wr level for the edge detector
    logic       wr_last;
    logic       wr_edge;
    // address the raster wants to read this clock
    logic [bg_pkg::ADDR_W-1:0] rd_addr;

    // horizontal counter, loadable like a pair of 161s
    // reloads with scroll_x at the end of each line
    // so pixel k of the next line sees scroll_x + k
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hpos <= 8'd0;
        end else if (pxl_cen) begin
            if (line_load) begin
                hpos <= scroll_x;
            end else begin
                // 8-bit counter wraps past 255 on its own
                hpos <= hpos + 8'd1;
            end
        end
    end

    // vertical latch
    // loaded for the coming line, so v_cnt + 1 plus the scroll
    // nine bit sum gives the mod 512 wrap for free
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vpos <= 9'd0;
        end else if (pxl_cen && line_load) begin
            vpos <= v_cnt + 9'd1 + scroll_y;
        end
    end

    // cpu write strobe is a level, a write is its rising edge
    // only counts while the chip select is held low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_last <= 1'b0;
        end else begin
            wr_last <= cpu_wr;
        end
    end

    assign wr_edge = cpu_wr & ~wr_last & ~cpu_cs_n;

    // upper half of the field (vpos[8] set) is off the tile map
    // it reads entry 0 so the output shows a flat colour there
    // otherwise row from vpos[6:1], tile column from hpos[7:2]
    assign rd_addr = vpos[8] ? '0 : {vpos[6:1], hpos[7:2]};

    // write enables, one clock wide
    // address msb picks which bank takes the nibble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bank_we <= '0;
        end else begin
            bank_we <= '0;
            if (wr_edge) begin
                bank_we[cpu_addr[bg_pkg::ADDR_W]] <= 1'b1;
            end
        end
    end

    // shared bank address
    // a write steals one clock, read address is late for that clock only
    always_ff @(posedge clk) begin
        if (wr_edge) begin
            addr  <= cpu_addr[bg_pkg::ADDR_W-1:0];
            wdata <= cpu_din;
        end else begin
            addr  <= rd_addr;
        end
    end

    // tile phase and half select go on to the output stage
    assign hpos_lo  = hpos[1:0];
    assign bank_sel = vpos[7];

endmodule

/* verilog/bg_pixel_out.sv */
// background pixel output stage with nibble select and tile boundary colour register
`timescale 1ns/1ps

module bg_pixel_out (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        pxl_cen,
    input  logic                                        cpu_cs_n,
    input  logic [1:0]                                  hpos_lo,
    input  logic                                        bank_sel,
    input  logic [bg_pkg::NUM_BANKS*bg_pkg::COLOR_W-1:0] bank_q,
    output logic [bg_pkg::COLOR_W-1:0]                  bakc
);

    // tile phase 3 means the last pixel of a four pixel tile
    logic                       phase3;
    logic                       phase3_last;
    logic                       load;
    // nibble of the half picked by vpos[7]
    logic [bg_pkg::COLOR_W-1:0] nibble;

    assign phase3 = (hpos_lo == 2'b11);

    // first pixel of phase 3 only, never twice in a row
    assign load = phase3 & ~phase3_last;

    // bank 0 keeps top half colours, bank 1 the bottom half
    assign nibble = bank_q[int'(bank_sel)*bg_pkg::COLOR_W +: bg_pkg::COLOR_W];

    // previous phase flag, sampled once per pixel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase3_last <= 1'b0;
        end else if (pxl_cen) begin
            phase3_last <= phase3;
        end
    end

    // colour register
    // by the end of phase 3 the bank output has settled on this tile
    // cpu access holds the last colour, the shared address is busy then
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bakc <= '0;
        end else if (pxl_cen && load && cpu_cs_n) begin
            bakc <= nibble;
        end
    end

endmodule

/* verilog/bg_pkg.sv */
// background memory geometry and video raster constants
package bg_pkg;

    // memory geometry
    // one bank holds 64 rows x 64 tile columns of colour nibbles
    localparam int ADDR_W    = 12;
    // colour nibble stored per tile in each bank
    localparam int COLOR_W   = 4;
    // bank 0 keeps the top half colours, bank 1 the bottom half
    // bank index is a single bit taken from the cpu address msb
    localparam int NUM_BANKS = 2;

    // horizontal raster, counted in pixel enables
    // total pixels per line, blanking included
    localparam int H_TOTAL   = 320;
    // first 256 pixels of each line are shown
    localparam int H_VIS     = 256;

    // vertical raster, counted in lines
    // total lines per frame
    localparam int V_TOTAL   = 264;
    // lines 0 to 223 are visible, the rest is vertical blanking
    localparam int V_VIS     = 224;

    // derived sizes
    // both raster counters fit in nine bits
    // the cpu address carries the bank bit on top of the bank address
    // a colour is one nibble of one bank at the shared address

endpackage

/* verilog/bg_tile_bank.sv */
// background memory bank, single port with registered read
`timescale 1ns/1ps

module bg_tile_bank #(
    parameter int ADDR_W = 12,
    parameter int DATA_W = 4
) (
    input  logic              clk,
    input  logic              we,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] wdata,
    output logic [DATA_W-1:0] q
);

    // one word per tile position
    logic [DATA_W-1:0] mem [2**ADDR_W];

    // write port, cpu side only
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // registered read, data one clock after the address
    // a write and a read on the same clock return the old word
    always_ff @(posedge clk) begin
        q <= mem[addr];
    end

endmodule

/* verilog/bg_top.sv */
// background layer top level with timing, address generator, memory banks and output stage
`timescale 1ns/1ps

module bg_top (
    input  logic                        clk,
    input  logic                        rst_n,
    // cpu port
    input  logic                        cpu_cs_n,
    input  logic                        cpu_wr,
    input  logic [bg_pkg::ADDR_W:0]     cpu_addr,
    input  logic [bg_pkg::COLOR_W-1:0]  cpu_din,
    // scroll levels, static while a frame runs
    input  logic [7:0]                  scroll_x,
    input  logic [8:0]                  scroll_y,
    // video side
    output logic [bg_pkg::COLOR_W-1:0]  bakc,
    output logic                        pxl_cen,
    output logic [8:0]                  h_cnt,
    output logic [8:0]                  v_cnt,
    output logic                        hblank,
    output logic                        vblank
);

    // end of line strobe from the timing block
    logic                                         line_load;
    // shared bank port
    logic [bg_pkg::ADDR_W-1:0]                    addr;
    logic [bg_pkg::COLOR_W-1:0]                   wdata;
    logic [bg_pkg::NUM_BANKS-1:0]                 bank_we;
    // read data of all banks, bank 0 in the low nibble
    logic [bg_pkg::NUM_BANKS*bg_pkg::COLOR_W-1:0] bank_q;
    // tile phase and half select for the output stage
    logic [1:0]                                   hpos_lo;
    logic                                         bank_sel;

    video_timing i_timing (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .h_cnt     (h_cnt),
        .v_cnt     (v_cnt),
        .hblank    (hblank),
        .vblank    (vblank),
        .line_load (line_load)
    );

    bg_addr_gen i_addr_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .line_load (line_load),
        .v_cnt     (v_cnt),
        .cpu_cs_n  (cpu_cs_n),
        .cpu_wr    (cpu_wr),
        .cpu_addr  (cpu_addr),
        .cpu_din   (cpu_din),
        .scroll_x  (scroll_x),
        .scroll_y  (scroll_y),
        .addr      (addr),
        .wdata     (wdata),
        .bank_we   (bank_we),
        .hpos_lo   (hpos_lo),
        .bank_sel  (bank_sel)
    );

    // all banks share address and data, each has its own write enable
    for (genvar i = 0; i < bg_pkg::NUM_BANKS; i++) begin : g_bank
        bg_tile_bank #(
            .ADDR_W (bg_pkg::ADDR_W),
            .DATA_W (bg_pkg::COLOR_W)
        ) i_bank (
            .clk   (clk),
            .we    (bank_we[i]),
            .addr  (addr),
            .wdata (wdata),
            .q     (bank_q[i*bg_pkg::COLOR_W +: bg_pkg::COLOR_W])
        );
    end

    bg_pixel_out i_pixel_out (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .cpu_cs_n (cpu_cs_n),
        .hpos_lo  (hpos_lo),
        .bank_sel (bank_sel),
        .bank_q   (bank_q),
        .bakc     (bakc)
    );

endmodule

/* verilog/video_timing.sv */
// video timing generator with pixel enable, raster counters, blanking and line load strobe
`timescale 1ns/1ps

module video_timing (
    input  logic       clk,
    input  logic       rst_n,
    output logic       pxl_cen,
    output logic [8:0] h_cnt,
    output logic [8:0] v_cnt,
    output logic       hblank,
    output logic       vblank,
    output logic       line_load
);

    // last pixel of a line and last line of a frame
    logic h_last;
    logic v_last;

    assign h_last = (h_cnt == 9'(bg_pkg::H_TOTAL - 1));
    assign v_last = (v_cnt == 9'(bg_pkg::V_TOTAL - 1));

    // pixel enable runs at half the clock rate
    // low on the first clock after reset, then high every second clock
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pxl_cen <= 1'b0;
        end else begin
            pxl_cen <= ~pxl_cen;
        end
    end

    // horizontal counter
    // advances once per pixel, wraps from 319 back to 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= 9'd0;
        end else if (pxl_cen) begin
            if (h_last) begin
                h_cnt <= 9'd0;
            end else begin
                h_cnt <= h_cnt + 9'd1;
            end
        end
    end

    // vertical counter
    // steps only when the line wraps, frame ends after line 263
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v_cnt <= 9'd0;
        end else if (pxl_cen && h_last) begin
            if (v_last) begin
                v_cnt <= 9'd0;
            end else begin
                v_cnt <= v_cnt + 9'd1;
            end
        end
    end

    // blanking levels decoded straight from the counters
    assign hblank = (h_cnt >= 9'(bg_pkg::H_VIS));
    assign vblank = (v_cnt >= 9'(bg_pkg::V_VIS));

    // end of line strobe
    // lasts a single clock, on the pixel enable of pixel 319
    // the address generator reloads its scroll counters on it
    assign line_load = pxl_cen & h_last;

endmodule
